//--- armPkg.sv
// Covers only the core's ARM subset (no shifts, rotations or writeback); any edit here affects every RTL file
package armPkg;

	typedef logic [31:0] word;
	typedef logic [3:0] regAddr;
	// Ordered N Z C V
	typedef logic [3:0] aluFlags;
	typedef logic [3:0] condCode;
	typedef logic [2:0] aluCtrl;

	typedef enum logic [3:0] {
		FETCH,
		DECODE,
		MEMADR,
		MEMRD,
		MEMWB,
		MEMWR,
		EXECUTER,
		EXECUTEI,
		ALUWB,
		BRANCH,
		UNKNOWN
	} fsmState;

	// Per-state control word from the main FSM
	typedef struct packed {
		logic nextPc;
		logic branch;
		logic memW;
		logic regW;
		logic irWrite;
		logic adrSrc;
		logic [1:0] resultSrc;
		logic aluSrcA;
		logic [1:0] aluSrcB;
		logic aluOp;
		logic memStart;
	} fsmCtrl;

	typedef struct packed {
		aluCtrl aluControl;
		logic [1:0] flagW;
		logic [1:0] immSrc;
		logic [1:0] regSrc;
		logic regSrcMul;
		logic pcs;
	} decodedCtrl;

	typedef struct packed {
		word addr;
		word writeData;
		logic write;
	} memRequest;

	localparam aluCtrl ALU_ADD = 3'b000;
	localparam aluCtrl ALU_SUB = 3'b001;
	localparam aluCtrl ALU_AND = 3'b010;
	localparam aluCtrl ALU_ORR = 3'b011;
	localparam aluCtrl ALU_EOR = 3'b100;
	localparam aluCtrl ALU_MUL = 3'b101;

	localparam logic [1:0] OP_DP = 2'b00;
	localparam logic [1:0] OP_MEM = 2'b01;
	localparam logic [1:0] OP_BRANCH = 2'b10;

	localparam logic [3:0] MUL_MOP = 4'b1001;
	localparam regAddr PC_REG = 4'd15;
	localparam condCode COND_AL = 4'b1110;
	localparam word PC_STEP = 32'd4;

endpackage

//--- alu.sv
// C and V are zero for anything but ADD and SUB; MUL returns only the low 32 bits
`timescale 1ns/1ps

module alu (
	input armPkg::word a,
	input armPkg::word b,
	input armPkg::aluCtrl control,
	output armPkg::word result,
	output armPkg::aluFlags flags
);
	logic isSub;
	logic isArith;
	armPkg::word condInvB;
	logic [32:0] sum;
	logic carry;
	logic overflow;

	assign isSub = control == armPkg::ALU_SUB;
	assign isArith = (control == armPkg::ALU_ADD) | isSub;
	// Subtract as a + ~b + 1
	assign condInvB = isSub ? ~b : b;
	assign sum = {1'b0, a} + {1'b0, condInvB} + {32'd0, isSub};

	always_comb begin
		case (control)
			armPkg::ALU_AND: result = a & b;
			armPkg::ALU_ORR: result = a | b;
			armPkg::ALU_EOR: result = a ^ b;
			armPkg::ALU_MUL: result = a * b;
			default: result = sum[31:0];
		endcase
	end

	assign carry = isArith & sum[32];
	assign overflow = isArith & ~(a[31] ^ b[31] ^ isSub) & (a[31] ^ sum[31]);
	assign flags = {result[31], result == '0, carry, overflow};

endmodule

//--- datapath.sv
// Register file has no reset and only R0-R14 storage; immediates are not rotated
`timescale 1ns/1ps

module datapath (
	input logic clk,
	input logic reset,
	input armPkg::fsmCtrl ctrl,
	input armPkg::decodedCtrl dec,
	input logic regWrite,
	input logic pcWrite,
	input logic memDone,
	input armPkg::word readData,
	output armPkg::word instr,
	output armPkg::aluFlags flags,
	output armPkg::memRequest request
);
	armPkg::word pc;
	armPkg::word dataReg;
	armPkg::word rf [0:14];
	armPkg::word rd1;
	armPkg::word rd2;
	armPkg::word aReg;
	armPkg::word bReg;
	armPkg::word extImm;
	armPkg::word srcA;
	armPkg::word srcB;
	armPkg::word aluResult;
	armPkg::word aluOut;
	armPkg::word result;
	armPkg::regAddr ra1;
	armPkg::regAddr ra2;
	armPkg::regAddr a3;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= '0;
			instr <= '0;
		end else begin
			if (pcWrite)
				pc <= result;
			if (ctrl.irWrite && memDone)
				instr <= readData;
		end
	end

	// Register sources, with the multiply operand swap
	assign ra1 = dec.regSrc[0] ? armPkg::PC_REG : (dec.regSrcMul ? instr[3:0] : instr[19:16]);
	assign ra2 = dec.regSrc[1] ? instr[15:12] : (dec.regSrcMul ? instr[11:8] : instr[3:0]);
	assign a3 = dec.regSrcMul ? instr[19:16] : instr[15:12];

	always_ff @(posedge clk) begin
		if (regWrite && a3 != armPkg::PC_REG)
			rf[a3] <= result;
	end

	// R15 reads the live result, PC+8 during DECODE
	assign rd1 = (ra1 == armPkg::PC_REG) ? result : rf[ra1];
	assign rd2 = (ra2 == armPkg::PC_REG) ? result : rf[ra2];

	always_ff @(posedge clk) begin
		aReg <= rd1;
		bReg <= rd2;
		aluOut <= aluResult;
		if (memDone)
			dataReg <= readData;
	end

	always_comb begin
		case (dec.immSrc)
			2'b00: extImm = {24'd0, instr[7:0]};
			2'b01: extImm = {20'd0, instr[11:0]};
			2'b10: extImm = {{6{instr[23]}}, instr[23:0], 2'b00};
			default: extImm = '0;
		endcase
	end

	assign srcA = ctrl.aluSrcA ? pc : aReg;

	always_comb begin
		case (ctrl.aluSrcB)
			2'd0: srcB = bReg;
			2'd1: srcB = extImm;
			default: srcB = armPkg::PC_STEP;
		endcase
	end

	alu alu_inst (
		.a(srcA),
		.b(srcB),
		.control(dec.aluControl),
		.result(aluResult),
		.flags(flags)
	);

	always_comb begin
		case (ctrl.resultSrc)
			2'd0: result = aluOut;
			2'd1: result = dataReg;
			default: result = aluResult;
		endcase
	end

	assign request.addr = ctrl.adrSrc ? result : pc;
	assign request.writeData = bReg;
	assign request.write = ctrl.memW;

endmodule

//--- condLogic.sv
// Condition is sampled once per instruction in DECODE; cond 1111 is treated as never
`timescale 1ns/1ps

module condLogic (
	input logic clk,
	input logic reset,
	input armPkg::word instr,
	input armPkg::aluFlags flags,
	input armPkg::fsmCtrl ctrl,
	input armPkg::decodedCtrl dec,
	input logic memDone,
	output logic regWrite,
	output logic memWrite,
	output logic pcWrite
);
	armPkg::aluFlags flagReg;
	armPkg::condCode cond;
	logic n;
	logic z;
	logic c;
	logic v;
	logic ge;
	logic condTrue;
	logic condEx;
	logic fetchDone;
	logic [1:0] flagWrite;

	assign cond = instr[31:28];
	assign {n, z, c, v} = flagReg;
	assign ge = n == v;

	always_comb begin
		case (cond)
			4'b0000: condTrue = z;
			4'b0001: condTrue = ~z;
			4'b0010: condTrue = c;
			4'b0011: condTrue = ~c;
			4'b0100: condTrue = n;
			4'b0101: condTrue = ~n;
			4'b0110: condTrue = v;
			4'b0111: condTrue = ~v;
			4'b1000: condTrue = c & ~z;
			4'b1001: condTrue = ~c | z;
			4'b1010: condTrue = ge;
			4'b1011: condTrue = ~ge;
			4'b1100: condTrue = ~z & ge;
			4'b1101: condTrue = z | ~ge;
			armPkg::COND_AL: condTrue = 1'b1;
			default: condTrue = 1'b0;
		endcase
	end

	// fetchDone marks DECODE, the cycle after the instruction register loads
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			fetchDone <= 1'b0;
			condEx <= 1'b0;
		end else begin
			fetchDone <= ctrl.irWrite & memDone;
			if (fetchDone)
				condEx <= condTrue;
		end
	end

	assign flagWrite = dec.flagW & {2{condEx}};

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			flagReg <= '0;
		else begin
			if (flagWrite[1])
				flagReg[3:2] <= flags[3:2];
			if (flagWrite[0])
				flagReg[1:0] <= flags[1:0];
		end
	end

	assign regWrite = ctrl.regW & condEx;
	assign memWrite = ctrl.memW & condEx;
	// Fetch advance only on the cycle the instruction arrives
	assign pcWrite = (dec.pcs & condEx) | (ctrl.nextPc & memDone);

endmodule

//--- instrDecoder.sv
// MUL is recognised only in register form with Mop 1001; other function codes fall back to ADD
`timescale 1ns/1ps

module instrDecoder (
	input armPkg::word instr,
	input armPkg::fsmCtrl ctrl,
	output armPkg::decodedCtrl dec
);
	logic [1:0] op;
	logic isMul;
	logic sFlag;
	armPkg::regAddr destReg;

	assign op = instr[27:26];
	assign sFlag = instr[20];
	assign isMul = (op == armPkg::OP_DP) & ~instr[25] & (instr[7:4] == armPkg::MUL_MOP);
	// Multiply writes Rd from bits 19:16
	assign destReg = isMul ? instr[19:16] : instr[15:12];

	always_comb begin
		dec.aluControl = armPkg::ALU_ADD;
		dec.flagW = 2'b00;
		if (ctrl.aluOp) begin
			if (isMul)
				dec.aluControl = armPkg::ALU_MUL;
			else begin
				case (instr[24:21])
					4'b0100: dec.aluControl = armPkg::ALU_ADD;
					4'b0010: dec.aluControl = armPkg::ALU_SUB;
					4'b0000: dec.aluControl = armPkg::ALU_AND;
					4'b1100: dec.aluControl = armPkg::ALU_ORR;
					4'b0001: dec.aluControl = armPkg::ALU_EOR;
					default: dec.aluControl = armPkg::ALU_ADD;
				endcase
			end
			// C and V only move on arithmetic
			dec.flagW[1] = sFlag;
			dec.flagW[0] = sFlag & ((dec.aluControl == armPkg::ALU_ADD) |
				(dec.aluControl == armPkg::ALU_SUB));
		end
	end

	assign dec.immSrc = op;
	assign dec.regSrc[1] = op == armPkg::OP_MEM;
	assign dec.regSrc[0] = op == armPkg::OP_BRANCH;
	assign dec.regSrcMul = isMul;
	assign dec.pcs = ((destReg == armPkg::PC_REG) & ctrl.regW) | ctrl.branch;

endmodule

//--- mainFsm.sv
// One instruction at a time; memory states wait on memDone without limit, undefined op values fall to UNKNOWN
`timescale 1ns/1ps

module mainFsm (
	input logic clk,
	input logic reset,
	input armPkg::word instr,
	input logic memDone,
	output armPkg::fsmCtrl ctrl
);
	armPkg::fsmState state;
	armPkg::fsmState nextState;
	logic [1:0] op;

	assign op = instr[27:26];

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			state <= armPkg::FETCH;
		else
			state <= nextState;
	end

	always_comb begin
		case (state)
			armPkg::FETCH:
				nextState = memDone ? armPkg::DECODE : armPkg::FETCH;
			armPkg::DECODE: begin
				if (op == armPkg::OP_DP)
					nextState = instr[25] ? armPkg::EXECUTEI : armPkg::EXECUTER;
				else if (op == armPkg::OP_MEM)
					nextState = armPkg::MEMADR;
				else if (op == armPkg::OP_BRANCH)
					nextState = armPkg::BRANCH;
				else
					nextState = armPkg::UNKNOWN;
			end
			// L bit picks load or store
			armPkg::MEMADR:
				nextState = instr[20] ? armPkg::MEMRD : armPkg::MEMWR;
			armPkg::MEMRD:
				nextState = memDone ? armPkg::MEMWB : armPkg::MEMRD;
			armPkg::MEMWR:
				nextState = memDone ? armPkg::FETCH : armPkg::MEMWR;
			armPkg::EXECUTER,
			armPkg::EXECUTEI:
				nextState = armPkg::ALUWB;
			default:
				nextState = armPkg::FETCH;
		endcase
	end

	// resultSrc 0 ALUOut, 1 data register, 2 live ALU result
	// aluSrcB 0 register, 1 immediate, 2 constant 4
	always_comb begin
		ctrl = '0;
		case (state)
			armPkg::FETCH: begin
				ctrl.nextPc = 1'b1;
				ctrl.irWrite = 1'b1;
				ctrl.resultSrc = 2'd2;
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = 2'd2;
				ctrl.memStart = 1'b1;
			end
			// PC+4 again so that an R15 read sees PC+8
			armPkg::DECODE: begin
				ctrl.resultSrc = 2'd2;
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = 2'd2;
			end
			armPkg::MEMADR:
				ctrl.aluSrcB = 2'd1;
			armPkg::MEMRD: begin
				ctrl.adrSrc = 1'b1;
				ctrl.memStart = 1'b1;
			end
			armPkg::MEMWB: begin
				ctrl.regW = 1'b1;
				ctrl.resultSrc = 2'd1;
			end
			armPkg::MEMWR: begin
				ctrl.adrSrc = 1'b1;
				ctrl.memW = 1'b1;
				ctrl.memStart = 1'b1;
			end
			armPkg::EXECUTER:
				ctrl.aluOp = 1'b1;
			armPkg::EXECUTEI: begin
				ctrl.aluOp = 1'b1;
				ctrl.aluSrcB = 2'd1;
			end
			armPkg::ALUWB:
				ctrl.regW = 1'b1;
			armPkg::BRANCH: begin
				ctrl.branch = 1'b1;
				ctrl.resultSrc = 2'd2;
				ctrl.aluSrcB = 2'd1;
			end
			default: ;
		endcase
	end

endmodule

//--- memBus.sv
// Waits forever on memAck in both phases; a new request starts only from idle and not in the done cycle
`timescale 1ns/1ps

module memBus (
	input logic clk,
	input logic reset,
	input logic memStart,
	input armPkg::memRequest requestIn,
	output logic memReq,
	input logic memAck,
	output armPkg::memRequest requestOut,
	input armPkg::word memReadData,
	output armPkg::word readData,
	output logic memDone
);
	typedef enum logic [1:0] {
		BUS_IDLE,
		BUS_WAIT_ACK,
		BUS_WAIT_RELEASE
	} busState;

	busState state;
	logic start;
	logic capture;

	// memStart is still high while memDone pulses, so skip that cycle
	assign start = (state == BUS_IDLE) & memStart & ~memDone;
	assign capture = (state == BUS_WAIT_ACK) & memAck;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= BUS_IDLE;
			memReq <= 1'b0;
			memDone <= 1'b0;
		end else begin
			memDone <= 1'b0;
			case (state)
				BUS_IDLE:
					if (start) begin
						memReq <= 1'b1;
						state <= BUS_WAIT_ACK;
					end
				BUS_WAIT_ACK:
					if (capture) begin
						memReq <= 1'b0;
						state <= BUS_WAIT_RELEASE;
					end
				default:
					if (!memAck) begin
						memDone <= 1'b1;
						state <= BUS_IDLE;
					end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			requestOut <= requestIn;
		if (capture)
			readData <= memReadData;
	end

endmodule

//--- armTop.sv
// Memory sits outside the core behind a four-phase req/ack port; it must hold memReadData while memAck is high
`timescale 1ns/1ps

module armTop (
	input logic clk,
	input logic reset,
	output logic memReq,
	input logic memAck,
	output armPkg::memRequest memRequestOut,
	input armPkg::word memReadData
);
	armPkg::fsmCtrl ctrl;
	armPkg::decodedCtrl dec;
	armPkg::word instr;
	armPkg::word readData;
	armPkg::aluFlags flags;
	armPkg::memRequest dpRequest;
	armPkg::memRequest busRequest;
	logic regWrite;
	logic memWrite;
	logic pcWrite;
	logic memDone;

	// Store intent from the datapath, gated by the condition outcome
	assign busRequest = '{
		addr: dpRequest.addr,
		writeData: dpRequest.writeData,
		write: dpRequest.write & memWrite
	};

	mainFsm mainFsm_inst (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.memDone(memDone),
		.ctrl(ctrl)
	);

	instrDecoder instrDecoder_inst (
		.instr(instr),
		.ctrl(ctrl),
		.dec(dec)
	);

	condLogic condLogic_inst (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.flags(flags),
		.ctrl(ctrl),
		.dec(dec),
		.memDone(memDone),
		.regWrite(regWrite),
		.memWrite(memWrite),
		.pcWrite(pcWrite)
	);

	datapath datapath_inst (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.dec(dec),
		.regWrite(regWrite),
		.pcWrite(pcWrite),
		.memDone(memDone),
		.readData(readData),
		.instr(instr),
		.flags(flags),
		.request(dpRequest)
	);

	memBus memBus_inst (
		.clk(clk),
		.reset(reset),
		.memStart(ctrl.memStart),
		.requestIn(busRequest),
		.memReq(memReq),
		.memAck(memAck),
		.requestOut(memRequestOut),
		.memReadData(memReadData),
		.readData(readData),
		.memDone(memDone)
	);

endmodule

//--- memBus_assertions.sv
// Covers the req/ack side of memBus only; all properties are disabled while reset is high
`timescale 1ns/1ps

module memBusAssertions (
	input logic clk,
	input logic reset,
	input logic memReq,
	input logic memAck,
	input armPkg::memRequest requestOut,
	input logic memDone
);
	int failCount = 0;

	// A new request waits until the previous ack is gone
	property reqRiseAckLow;
		@(posedge clk) disable iff (reset) $rose(memReq) |-> !$past(memAck);
	endproperty

	property requestStable;
		@(posedge clk) disable iff (reset) memReq && $past(memReq) |-> $stable(requestOut);
	endproperty

	// Request drops only on the cycle after ack was seen
	property reqFallAfterAck;
		@(posedge clk) disable iff (reset) $fell(memReq) |-> $past(memAck);
	endproperty

	property donePulse;
		@(posedge clk) disable iff (reset) memDone |=> !memDone;
	endproperty

	reqRiseCheck: assert property (reqRiseAckLow)
		else begin
			$error("memReq rose while memAck was high");
			failCount++;
		end
	stableCheck: assert property (requestStable)
		else begin
			$error("Request fields changed while memReq was high");
			failCount++;
		end
	fallCheck: assert property (reqFallAfterAck)
		else begin
			$error("memReq fell without a preceding memAck");
			failCount++;
		end
	doneCheck: assert property (donePulse)
		else begin
			$error("memDone stayed high for more than one cycle");
			failCount++;
		end

endmodule

bind memBus memBusAssertions memBusAssertions_inst (
	.clk(clk),
	.reset(reset),
	.memReq(memReq),
	.memAck(memAck),
	.requestOut(requestOut),
	.memDone(memDone)
);

//--- armTb.sv
// Self-checking run of one random program; memory is a 128-word array here, code in words 0-95
`timescale 1ns/1ps

module armTb;
	localparam int EPILOGUE_START = 76;
	localparam int HALT_WORD = 95;
	localparam armPkg::word HALT_ADDR = 32'd380;
	localparam armPkg::word DATA_BASE = 32'd384;
	localparam armPkg::word MEM_BYTES = 32'd512;
	localparam int ACK_TIMEOUT = 64;
	localparam int RUN_TIMEOUT = 20000;
	localparam int MODEL_STEPS = 2000;

	logic clk;
	logic reset;
	logic memReq;
	logic memAck;
	armPkg::memRequest memRequestOut;
	armPkg::word memReadData;

	armPkg::word tbMem [0:127];
	armPkg::word modelMem [0:127];
	armPkg::word expFetch [$];
	armPkg::word expStoreAddr [$];
	armPkg::word expStoreData [$];
	logic [31:0] lfsrState;
	int fetchIndex = 0;
	int storeIndex = 0;
	int fetchErrors = 0;
	int storeErrors = 0;
	int memErrors = 0;
	int otherErrors = 0;
	bit runStarted = 1'b0;
	bit halted = 1'b0;
	bit timedOut = 1'b0;

	armTop armTop_inst (
		.clk(clk),
		.reset(reset),
		.memReq(memReq),
		.memAck(memAck),
		.memRequestOut(memRequestOut),
		.memReadData(memReadData)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] randBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], lfsrState[0]};
			if (lfsrState[0])
				lfsrState = (lfsrState >> 1) ^ 32'hA3000000;
			else
				lfsrState = lfsrState >> 1;
		end
		return value;
	endfunction

	function automatic armPkg::regAddr pickReg();
		return armPkg::regAddr'(randBits(4) % 13);
	endfunction

	function automatic logic [3:0] funcCode(input int k);
		case (k)
			0: return 4'b0100;
			1: return 4'b0010;
			2: return 4'b0000;
			3: return 4'b1100;
			default: return 4'b0001;
		endcase
	endfunction

	function automatic armPkg::word dpImmInstr(input armPkg::condCode cond, input logic [3:0] func,
		input logic s, input armPkg::regAddr rn, input armPkg::regAddr rd, input logic [7:0] imm);
		return {cond, 2'b00, 1'b1, func, s, rn, rd, 4'h0, imm};
	endfunction

	function automatic armPkg::word dpRegInstr(input armPkg::condCode cond, input logic [3:0] func,
		input logic s, input armPkg::regAddr rn, input armPkg::regAddr rd, input armPkg::regAddr rm);
		return {cond, 2'b00, 1'b0, func, s, rn, rd, 8'h00, rm};
	endfunction

	function automatic armPkg::word mulInstr(input armPkg::condCode cond, input logic s,
		input armPkg::regAddr rd, input armPkg::regAddr rm, input armPkg::regAddr rs);
		return {cond, 6'b000000, 1'b0, s, rd, 4'h0, rs, 4'b1001, rm};
	endfunction

	// Base is always R13 and the offset counts words
	function automatic armPkg::word memInstr(input armPkg::condCode cond, input logic load,
		input armPkg::regAddr rd, input logic [4:0] offset);
		return {cond, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, load, 4'd13, rd, 5'd0, offset, 2'b00};
	endfunction

	function automatic armPkg::word branchInstr(input armPkg::condCode cond, input logic [23:0] imm);
		return {cond, 4'b1010, imm};
	endfunction

	function automatic logic condHolds(input logic [3:0] cond, input logic n, input logic z,
		input logic c, input logic v);
		case (cond)
			4'b0000: return z;
			4'b0001: return !z;
			4'b0010: return c;
			4'b0011: return !c;
			4'b0100: return n;
			4'b0101: return !n;
			4'b0110: return v;
			4'b0111: return !v;
			4'b1000: return c && !z;
			4'b1001: return !c || z;
			4'b1010: return n == v;
			4'b1011: return n != v;
			4'b1100: return !z && (n == v);
			4'b1101: return z || (n != v);
			4'b1110: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	task automatic reportMismatch(input string name, input armPkg::word got,
		input armPkg::word expected);
		$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, expected);
	endtask

	task automatic buildProgram();
		int pos;
		int kind;
		int limit;
		int imm;
		armPkg::condCode cond;
		logic [3:0] func;
		logic s;
		armPkg::regAddr rd;
		armPkg::regAddr rn;
		armPkg::regAddr rm;
		pos = 0;
		// Prologue clears and loads R0-R12, then R13 = 192 + 192
		for (int r = 0; r < 13; r++) begin
			rd = armPkg::regAddr'(r);
			tbMem[pos] = dpImmInstr(armPkg::COND_AL, 4'b0000, 1'b0, rd, rd, 8'h00);
			tbMem[pos + 1] = dpImmInstr(armPkg::COND_AL, 4'b1100, 1'b0, rd, rd, 8'(randBits(8)));
			pos = pos + 2;
		end
		tbMem[pos] = dpImmInstr(armPkg::COND_AL, 4'b0000, 1'b0, 4'd13, 4'd13, 8'h00);
		tbMem[pos + 1] = dpImmInstr(armPkg::COND_AL, 4'b1100, 1'b0, 4'd13, 4'd13, 8'd192);
		tbMem[pos + 2] = dpRegInstr(armPkg::COND_AL, 4'b0100, 1'b0, 4'd13, 4'd13, 4'd13);
		pos = pos + 3;
		while (pos < EPILOGUE_START) begin
			cond = 4'(randBits(4));
			if (cond == 4'hF)
				cond = armPkg::COND_AL;
			kind = int'(randBits(3));
			func = funcCode(int'(randBits(3) % 5));
			s = 1'(randBits(1));
			rd = pickReg();
			rn = pickReg();
			rm = pickReg();
			limit = EPILOGUE_START - pos - 2;
			if (kind == 7 && limit < 0)
				kind = 2;
			case (kind)
				0, 1: tbMem[pos] = dpRegInstr(cond, func, s, rn, rd, rm);
				2, 3: tbMem[pos] = dpImmInstr(cond, func, s, rn, rd, 8'(randBits(8)));
				4: tbMem[pos] = mulInstr(cond, s, rd, rn, rm);
				5: tbMem[pos] = memInstr(cond, 1'b1, rd, 5'(randBits(5)));
				6: tbMem[pos] = memInstr(cond, 1'b0, rd, 5'(randBits(5)));
				default: begin
					imm = int'(randBits(3));
					if (imm > limit)
						imm = limit;
					tbMem[pos] = branchInstr(cond, 24'(imm));
				end
			endcase
			pos++;
		end
		// Epilogue stores R0-R12, then the flags packed as NZCV in one word
		for (int r = 0; r < 13; r++)
			tbMem[pos + r] = memInstr(armPkg::COND_AL, 1'b0, armPkg::regAddr'(r), 5'(r));
		pos = pos + 13;
		tbMem[pos] = dpImmInstr(armPkg::COND_AL, 4'b0000, 1'b0, 4'd0, 4'd0, 8'h00);
		tbMem[pos + 1] = dpImmInstr(4'b0100, 4'b1100, 1'b0, 4'd0, 4'd0, 8'd8);
		tbMem[pos + 2] = dpImmInstr(4'b0000, 4'b1100, 1'b0, 4'd0, 4'd0, 8'd4);
		tbMem[pos + 3] = dpImmInstr(4'b0010, 4'b1100, 1'b0, 4'd0, 4'd0, 8'd2);
		tbMem[pos + 4] = dpImmInstr(4'b0110, 4'b1100, 1'b0, 4'd0, 4'd0, 8'd1);
		tbMem[pos + 5] = memInstr(armPkg::COND_AL, 1'b0, 4'd0, 5'd13);
		// Branch to self since PC+8-8 is its own address
		tbMem[HALT_WORD] = branchInstr(armPkg::COND_AL, 24'hFFFFFE);
		for (int i = 96; i < 128; i++)
			tbMem[i] = randBits(32);
		for (int i = 0; i < 128; i++)
			modelMem[i] = tbMem[i];
	endtask

	// ISA-level execution of the program with one instruction per step
	task automatic runModel();
		armPkg::word regs [0:15];
		armPkg::word pc;
		armPkg::word nextPc;
		armPkg::word ins;
		armPkg::word a;
		armPkg::word b;
		armPkg::word res;
		armPkg::word addr;
		logic [32:0] wide;
		logic n;
		logic z;
		logic c;
		logic v;
		logic done;
		int steps;
		for (int i = 0; i < 16; i++)
			regs[i] = '0;
		{n, z, c, v} = 4'b0000;
		pc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < MODEL_STEPS) begin
			expFetch.push_back(pc);
			ins = modelMem[pc[8:2]];
			steps++;
			if (pc == HALT_ADDR)
				done = 1'b1;
			else begin
				nextPc = pc + 32'd4;
				if (condHolds(ins[31:28], n, z, c, v)) begin
					case (ins[27:26])
						2'b00: begin
							a = regs[ins[19:16]];
							b = ins[25] ? {24'd0, ins[7:0]} : regs[ins[3:0]];
							if (!ins[25] && ins[7:4] == 4'b1001) begin
								res = regs[ins[3:0]] * regs[ins[11:8]];
								regs[ins[19:16]] = res;
								if (ins[20]) begin
									n = res[31];
									z = (res == '0);
								end
							end else begin
								wide = {1'b0, a} + {1'b0, b};
								case (ins[24:21])
									4'b0100: res = wide[31:0];
									4'b0010: res = a - b;
									4'b0000: res = a & b;
									4'b1100: res = a | b;
									default: res = a ^ b;
								endcase
								regs[ins[15:12]] = res;
								if (ins[20]) begin
									n = res[31];
									z = (res == '0);
									if (ins[24:21] == 4'b0100) begin
										c = wide[32];
										v = (a[31] == b[31]) && (res[31] != a[31]);
									end
									if (ins[24:21] == 4'b0010) begin
										c = (a >= b);
										v = (a[31] != b[31]) && (res[31] != a[31]);
									end
								end
							end
						end
						2'b01: begin
							addr = regs[ins[19:16]] + {20'd0, ins[11:0]};
							if (ins[20])
								regs[ins[15:12]] = modelMem[addr[8:2]];
							else begin
								modelMem[addr[8:2]] = regs[ins[15:12]];
								expStoreAddr.push_back(addr);
								expStoreData.push_back(regs[ins[15:12]]);
							end
						end
						default:
							nextPc = pc + 32'd8 + {{6{ins[23]}}, ins[23:0], 2'b00};
					endcase
				end
				pc = nextPc;
			end
		end
		if (!done) begin
			$display("Reference model did not reach the halt branch in %0d steps", MODEL_STEPS);
			otherErrors++;
		end
	endtask

	// Classifies one request, checks it and serves the memory side
	task automatic handleRequest(input armPkg::memRequest req);
		logic [6:0] idx;
		idx = req.addr[8:2];
		memReadData = '0;
		if (req.addr >= MEM_BYTES || req.addr[1:0] != 2'b00) begin
			$display("Access outside the memory or unaligned at %0t, address %h", $time, req.addr);
			otherErrors++;
		end else if (req.write) begin
			if (storeIndex < expStoreAddr.size()) begin
				if (req.addr !== expStoreAddr[storeIndex]) begin
					reportMismatch("memRequestOut.addr", req.addr, expStoreAddr[storeIndex]);
					storeErrors++;
				end
				if (req.writeData !== expStoreData[storeIndex]) begin
					reportMismatch("memRequestOut.writeData", req.writeData,
						expStoreData[storeIndex]);
					storeErrors++;
				end
			end else begin
				$display("Store at %0t that the program never executes, address %h", $time,
					req.addr);
				storeErrors++;
			end
			storeIndex++;
			tbMem[idx] = req.writeData;
		end else begin
			memReadData = tbMem[idx];
			if (req.addr < DATA_BASE && !halted) begin
				if (fetchIndex < expFetch.size()) begin
					if (req.addr !== expFetch[fetchIndex]) begin
						reportMismatch("memRequestOut.addr (fetch)", req.addr,
							expFetch[fetchIndex]);
						fetchErrors++;
					end
				end
				fetchIndex++;
				if (fetchIndex >= expFetch.size())
					halted = 1'b1;
			end
		end
	endtask

	// Memory responder with random ack and release delays
	initial begin : responder
		armPkg::memRequest req;
		int cycles;
		int delay;
		cycles = 0;
		while (!runStarted && cycles < ACK_TIMEOUT) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!runStarted) begin
			$display("Timeout: reset was not released within %0d cycles", ACK_TIMEOUT);
			otherErrors++;
			timedOut = 1'b1;
		end
		while (!timedOut) begin
			cycles = 0;
			while (!memReq && cycles < ACK_TIMEOUT) begin
				@(posedge clk);
				#1;
				cycles++;
			end
			if (!memReq) begin
				$display("Timeout: no memory request within %0d cycles at %0t", ACK_TIMEOUT, $time);
				otherErrors++;
				timedOut = 1'b1;
			end else begin
				req = memRequestOut;
				handleRequest(req);
				delay = int'(randBits(2));
				repeat (delay) begin
					@(posedge clk);
					#1;
				end
				memAck = 1'b1;
				cycles = 0;
				while (memReq && cycles < ACK_TIMEOUT) begin
					@(posedge clk);
					#1;
					cycles++;
				end
				if (memReq) begin
					$display("Timeout: memReq still high %0d cycles after ack at %0t", ACK_TIMEOUT,
						$time);
					otherErrors++;
					timedOut = 1'b1;
				end else begin
					delay = int'(randBits(2));
					repeat (delay) begin
						@(posedge clk);
						#1;
					end
					memAck = 1'b0;
				end
			end
		end
	end

	initial begin : mainSequence
		int cycles;
		int assertErrors;
		lfsrState = 32'hb239;
		reset = 1'b1;
		memAck = 1'b0;
		memReadData = '0;
		buildProgram();
		runModel();
		repeat (4) begin
			@(posedge clk);
			#1;
			if (memReq !== 1'b0) begin
				$display("Memory request raised during reset at %0t", $time);
				otherErrors++;
			end
		end
		reset = 1'b0;
		runStarted = 1'b1;
		cycles = 0;
		while (!halted && !timedOut && cycles < RUN_TIMEOUT) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!halted && !timedOut) begin
			$display("Timeout: program did not reach the halt branch within %0d cycles",
				RUN_TIMEOUT);
			otherErrors++;
		end
		if (halted) begin
			for (int i = 96; i < 128; i++) begin
				if (tbMem[i] !== modelMem[i]) begin
					reportMismatch($sformatf("mem[%0d]", i), tbMem[i], modelMem[i]);
					memErrors++;
				end
			end
			if (storeIndex != expStoreAddr.size()) begin
				$display("Store count differs: %0d seen, %0d expected", storeIndex,
					expStoreAddr.size());
				storeErrors++;
			end
		end
		assertErrors = armTop_inst.memBus_inst.memBusAssertions_inst.failCount;
		$display("Error counts: fetch %0d, store %0d, memory %0d, assertion %0d, other %0d",
			fetchErrors, storeErrors, memErrors, assertErrors, otherErrors);
		if (fetchErrors + storeErrors + memErrors + assertErrors + otherErrors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- verilog.f
armPkg.sv
alu.sv
datapath.sv
condLogic.sv
instrDecoder.sv
mainFsm.sv
memBus.sv
armTop.sv
memBus_assertions.sv
armTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module armTb

status=0
./obj_dir/VarmTb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Errors found" sim.log; then
	exit 1
fi
exit "$status"
